// File: all.f
+incdir+src
src/usb_reg_pkg.sv
src/reg_bus_if.sv
src/reg_host_port.sv
src/reg_bank.sv
src/readback_collector.sv
src/usb_reg_top.sv
sim/tb_clkgen.sv
sim/tb_usb_reg.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the register bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
   -f all.f --top-module tb_usb_reg -o tb_usb_reg

./obj_dir/tb_usb_reg | tee sim.log

if grep -qx "Simulation finished: PASS" sim.log; then
   echo "run_sim: passed"
else
   echo "run_sim: failed, see sim.log"
   exit 1
fi

// File: sim/tb_usb_reg.sv
`timescale 1ns/1ps
`include "usb_reg_defines.svh"

module tb_usb_reg;
   import usb_reg_pkg::*;

   localparam int NB          = `USB_REG_NUM_BANKS;
   localparam int CLK_PERIOD  = 20;
   localparam int ACK_LATENCY = 3;
   localparam int ACK_LIMIT   = 16;   // cycles before an access counts as lost
   localparam int LED_WINDOW  = 32;
   localparam int N_ACCESS    = 158;  // accesses over all five tests
   localparam int WATCHDOG_CYCLES = N_ACCESS * 10 + 2 * LED_WINDOW + 200;
   localparam reg_addr_t HIGH_ADDRS [5] = '{8'h40, 8'h7F, 8'h80, 8'hC3, 8'hFF};

   logic          clk_usb_buf;
   logic          arst_n_i;
   logic          req_i;
   logic          we_i;
   reg_addr_t     addr_i;
   reg_data_t     wdata_i;
   logic [NB-1:0] err_event_i;
   logic          ack_o;
   reg_data_t     rdata_o;
   logic          led_error_o;

   reg_data_t     model_regs [NB][`USB_REG_BANK_REGS];
   logic [NB-1:0] model_err;
   int            seed = 82395;
   int            err_cnt = 0;
   int            test_cnt = 0;
   int            access_cnt = 0;
   int            check_cnt = 0;
   int            test_err_start = 0;
   reg_data_t     exp_rdata = '0;
   logic          exp_valid = 1'b0;
   logic          ack_prev = 1'b0;

   tb_clkgen #(
      .PERIOD_NS   (CLK_PERIOD),
      .RST_CYCLES  (8)
   ) i_tb_clkgen (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_o    (arst_n_i)
   );

   usb_reg_top i_usb_reg_top (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .req_i       (req_i),
      .we_i        (we_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .err_event_i (err_event_i),
      .ack_o       (ack_o),
      .rdata_o     (rdata_o),
      .led_error_o (led_error_o)
   );

   function automatic reg_addr_t reg_addr(input int bank, input int idx);
      return reg_addr_t'(bank * `USB_REG_BANK_STRIDE + idx);
   endfunction

   // expected byte from the address map: window = addr / stride, register = addr % stride
   function automatic reg_data_t expected_read(input reg_addr_t addr);
      logic [3:0] win;
      logic [3:0] ofs;
      reg_data_t  val;
      win = 4'(addr / `USB_REG_BANK_STRIDE);
      ofs = 4'(addr % `USB_REG_BANK_STRIDE);
      val = '0;
      if ((win < 4'(NB)) && (ofs < 4'(`USB_REG_BANK_REGS))) begin
         if (ofs == 4'(`USB_REG_ERR_REG)) begin
            val = reg_data_t'(model_err[bank_idx_t'(win)]);
         end else begin
            val = model_regs[bank_idx_t'(win)][3'(ofs)];
         end
      end
      return val;
   endfunction

   function automatic void model_write(input reg_addr_t addr, input reg_data_t data);
      logic [3:0] win;
      logic [3:0] ofs;
      win = 4'(addr / `USB_REG_BANK_STRIDE);
      ofs = 4'(addr % `USB_REG_BANK_STRIDE);
      if ((win < 4'(NB)) && (ofs < 4'(`USB_REG_BANK_REGS))) begin
         if (ofs == 4'(`USB_REG_ERR_REG)) begin
            if (data[0]) begin
               model_err[bank_idx_t'(win)] = 1'b0;  // write one to clear
            end
         end else begin
            model_regs[bank_idx_t'(win)][3'(ofs)] = data;
         end
      end
   endfunction

   // one four-phase access, also checks the ack timing
   task automatic bus_access(input logic write, input reg_addr_t addr, input reg_data_t data,
                             input int hold);
      int   cycles;
      logic ack_seen;
      cycles   = 0;
      ack_seen = 1'b0;
      @(posedge clk_usb_buf);
      exp_rdata = expected_read(addr);
      exp_valid = !write;
      req_i   <= 1'b1;
      we_i    <= write;
      addr_i  <= addr;
      wdata_i <= data;
      while (!ack_seen && (cycles < ACK_LIMIT)) begin
         @(posedge clk_usb_buf);
         cycles++;
         @(negedge clk_usb_buf);
         ack_seen = ack_o;
      end
      assert (ack_seen) else begin
         $display("ERROR at %0t: no ack for address %02h within %0d cycles",
                  $time, addr, ACK_LIMIT);
         err_cnt++;
      end
      if (ack_seen) begin
         assert (cycles - 1 == ACK_LATENCY) else begin
            $display("ERROR at %0t: ack_o latency expected %0d got %0d",
                     $time, ACK_LATENCY, cycles - 1);
            err_cnt++;
         end
      end
      repeat (hold) begin
         @(posedge clk_usb_buf);
         @(negedge clk_usb_buf);
         assert (ack_o === 1'b1) else begin
            $display("ERROR at %0t: ack_o expected 1 got %b while req_i held", $time, ack_o);
            err_cnt++;
         end
      end
      @(posedge clk_usb_buf);
      req_i <= 1'b0;
      @(negedge clk_usb_buf);
      assert (ack_o === 1'b1) else begin
         $display("ERROR at %0t: ack_o expected 1 got %b before req_i seen low", $time, ack_o);
         err_cnt++;
      end
      @(negedge clk_usb_buf);
      assert (ack_o === 1'b0) else begin
         $display("ERROR at %0t: ack_o expected 0 got %b after req_i dropped", $time, ack_o);
         err_cnt++;
      end
      if (write) begin
         model_write(addr, data);
      end
      exp_valid = 1'b0;
      access_cnt++;
   endtask

   task automatic count_led_toggles(input int cycles, output int toggles);
      logic last;
      toggles = 0;
      @(negedge clk_usb_buf);
      last = led_error_o;
      repeat (cycles) begin
         @(negedge clk_usb_buf);
         if (led_error_o !== last) begin
            toggles++;
         end
         last = led_error_o;
      end
   endtask

   task automatic report_test(input string name);
      test_cnt++;
      if (err_cnt == test_err_start) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_start);
      end
      test_err_start = err_cnt;
   endtask

   // read data compare on each rising ack
   always @(negedge clk_usb_buf) begin
      if (ack_o && !ack_prev && exp_valid) begin
         check_cnt++;
         assert (rdata_o === exp_rdata) else begin
            $display("ERROR at %0t: rdata_o expected %02h got %02h", $time, exp_rdata, rdata_o);
            err_cnt++;
         end
      end
      ack_prev = ack_o;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      int toggles;
      req_i       <= 1'b0;
      we_i        <= 1'b0;
      addr_i      <= '0;
      wdata_i     <= '0;
      err_event_i <= '0;
      model_err = '0;
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < `USB_REG_BANK_REGS; r++) begin
            model_regs[b][r] = '0;
         end
      end
      wait (arst_n_i === 1'b1);
      repeat (2) @(posedge clk_usb_buf);

      // test 1: random fill of every bank, then readback
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < `USB_REG_ERR_REG; r++) begin
            bus_access(1'b1, reg_addr(b, r), reg_data_t'($random(seed)), 0);
         end
      end
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < `USB_REG_ERR_REG; r++) begin
            bus_access(1'b0, reg_addr(b, r), '0, 0);
         end
      end
      report_test("register write and readback");

      // test 2: holes in each window and space above the last bank
      for (int b = 0; b < NB; b++) begin
         bus_access(1'b1, reg_addr(b, 8), reg_data_t'($random(seed)), 0);
         bus_access(1'b1, reg_addr(b, 15), reg_data_t'($random(seed)), 0);
      end
      foreach (HIGH_ADDRS[i]) begin
         bus_access(1'b1, HIGH_ADDRS[i], reg_data_t'($random(seed)), 0);
      end
      for (int b = 0; b < NB; b++) begin
         for (int r = 8; r < `USB_REG_BANK_STRIDE; r++) begin
            bus_access(1'b0, reg_addr(b, r), '0, 0);
         end
      end
      foreach (HIGH_ADDRS[i]) begin
         bus_access(1'b0, HIGH_ADDRS[i], '0, 0);
      end
      for (int b = 0; b < NB; b++) begin
         for (int r = 0; r < `USB_REG_ERR_REG; r++) begin
            bus_access(1'b0, reg_addr(b, r), '0, 0);
         end
      end
      report_test("unmapped addresses");

      // test 3: error events on banks 1 and 2
      @(posedge clk_usb_buf);
      err_event_i <= 4'b0110;
      @(posedge clk_usb_buf);
      err_event_i <= 4'b0000;
      model_err[1] = 1'b1;
      model_err[2] = 1'b1;
      for (int b = 0; b < NB; b++) begin
         bus_access(1'b0, reg_addr(b, `USB_REG_ERR_REG), '0, 0);
      end
      count_led_toggles(LED_WINDOW, toggles);
      assert (toggles >= 2) else begin
         $display("ERROR at %0t: led_error_o toggles expected at least 2 got %0d",
                  $time, toggles);
         err_cnt++;
      end
      report_test("sticky error and led flash");

      // test 4: clear bank 2, a write with bit 0 low leaves bank 1 set
      bus_access(1'b1, reg_addr(2, `USB_REG_ERR_REG), 8'h01, 0);
      for (int b = 0; b < NB; b++) begin
         bus_access(1'b0, reg_addr(b, `USB_REG_ERR_REG), '0, 0);
      end
      bus_access(1'b1, reg_addr(1, `USB_REG_ERR_REG), 8'hFE, 0);
      bus_access(1'b0, reg_addr(1, `USB_REG_ERR_REG), '0, 0);
      bus_access(1'b1, reg_addr(1, `USB_REG_ERR_REG), 8'h01, 0);
      for (int b = 0; b < NB; b++) begin
         bus_access(1'b0, reg_addr(b, `USB_REG_ERR_REG), '0, 0);
      end
      count_led_toggles(LED_WINDOW, toggles);
      assert ((toggles == 0) && (led_error_o === 1'b0)) else begin
         $display("ERROR at %0t: led_error_o expected to stay 0, saw %0d toggles",
                  $time, toggles);
         err_cnt++;
      end
      report_test("error clear");

      // test 5: request held for a growing number of cycles after ack
      for (int h = 0; h < 8; h++) begin
         if (h % 2 == 0) begin
            bus_access(1'b1, reg_addr(h % NB, h % 7), reg_data_t'($random(seed)), h);
         end else begin
            bus_access(1'b0, reg_addr(h % NB, (h - 1) % 7), '0, h);
         end
      end
      report_test("handshake timing");

      $display("tests %0d, accesses %0d, read checks %0d, errors %0d",
               test_cnt, access_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS  = 20,
   parameter int RST_CYCLES = 8
) (
   output logic clk_usb_buf,
   output logic arst_n_o
);

   initial begin
      clk_usb_buf = 1'b0;
      forever #(PERIOD_NS / 2) clk_usb_buf = ~clk_usb_buf;
   end

   // reset held low for a fixed number of cycles
   initial begin
      arst_n_o <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk_usb_buf);
      arst_n_o <= 1'b1;
   end

endmodule

// File: src/usb_reg_top.sv
`timescale 1ns/1ps
`include "usb_reg_defines.svh"

module usb_reg_top (
   input  logic                          clk_usb_buf,
   input  logic                          arst_n_i,
   input  logic                          req_i,
   input  logic                          we_i,
   input  usb_reg_pkg::reg_addr_t        addr_i,
   input  usb_reg_pkg::reg_data_t        wdata_i,
   input  logic [`USB_REG_NUM_BANKS-1:0] err_event_i,
   output logic                          ack_o,
   output usb_reg_pkg::reg_data_t        rdata_o,
   output logic                          led_error_o
);
   import usb_reg_pkg::*;

   reg_data_t                     bank_rdata [`USB_REG_NUM_BANKS];
   logic [`USB_REG_NUM_BANKS-1:0] bank_err;
   reg_data_t                     rdata_q;   // registered OR of all banks

   reg_bus_if bus_if ();

   reg_host_port i_reg_host_port (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .req_i       (req_i),
      .we_i        (we_i),
      .addr_i      (addr_i),
      .wdata_i     (wdata_i),
      .rdata_q_i   (rdata_q),
      .ack_o       (ack_o),
      .rdata_o     (rdata_o),
      .bus         (bus_if.host)
   );

   // one bank per address window
   for (genvar g = 0; g < `USB_REG_NUM_BANKS; g++) begin : g_bank
      reg_bank #(
         .BANK_INDEX  (g)
      ) i_reg_bank (
         .clk_usb_buf (clk_usb_buf),
         .arst_n_i    (arst_n_i),
         .bus         (bus_if.bank),
         .err_event_i (err_event_i[g]),
         .rdata_o     (bank_rdata[g]),
         .err_o       (bank_err[g])
      );
   end

   readback_collector i_readback_collector (
      .clk_usb_buf  (clk_usb_buf),
      .arst_n_i     (arst_n_i),
      .bank_rdata_i (bank_rdata),
      .bank_err_i   (bank_err),
      .rdata_q_o    (rdata_q),
      .led_error_o  (led_error_o)
   );

endmodule

// File: src/readback_collector.sv
`timescale 1ns/1ps
`include "usb_reg_defines.svh"

module readback_collector (
   input  logic                          clk_usb_buf,
   input  logic                          arst_n_i,
   input  usb_reg_pkg::reg_data_t        bank_rdata_i [`USB_REG_NUM_BANKS],
   input  logic [`USB_REG_NUM_BANKS-1:0] bank_err_i,
   output usb_reg_pkg::reg_data_t        rdata_q_o,
   output logic                          led_error_o
);
   import usb_reg_pkg::*;

   localparam int FLASH_MSB = `USB_REG_FLASH_W - 1;

   reg_data_t                   rdata_or;
   reg_data_t                   rdata_q;
   logic                        err_any;
   logic [`USB_REG_FLASH_W-1:0] flash_cnt_q;
   logic                        led_q;

   // idle banks present zero, so a plain OR selects the responder
   always_comb begin
      rdata_or = '0;
      for (int b = 0; b < `USB_REG_NUM_BANKS; b++) begin
         rdata_or = rdata_or | bank_rdata_i[b];
      end
   end

   assign err_any = |bank_err_i;

   always_ff @(posedge clk_usb_buf) begin
      rdata_q <= rdata_or;
   end

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         flash_cnt_q <= '0;
      end else begin
         flash_cnt_q <= flash_cnt_q + 1'b1;  // free running
      end
   end

   // flash while any error is pending
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         led_q <= 1'b0;
      end else begin
         led_q <= err_any && flash_cnt_q[FLASH_MSB];
      end
   end

   assign rdata_q_o   = rdata_q;
   assign led_error_o = led_q;

   a_led_quiet: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      !err_any |=> !led_error_o);

endmodule

// File: src/reg_bank.sv
`timescale 1ns/1ps
`include "usb_reg_defines.svh"

module reg_bank #(
   parameter int BANK_INDEX = 0
) (
   input  logic                   clk_usb_buf,
   input  logic                   arst_n_i,
   reg_bus_if.bank                bus,
   input  logic                   err_event_i,
   output usb_reg_pkg::reg_data_t rdata_o,
   output logic                   err_o
);
   import usb_reg_pkg::*;

   localparam int OFS_W     = $clog2(`USB_REG_BANK_STRIDE);
   localparam int IDX_W     = $bits(bank_idx_t);
   localparam int TOP_LSB   = OFS_W + IDX_W;
   localparam int REG_IDX_W = $clog2(`USB_REG_BANK_REGS);

   logic [OFS_W-1:0] reg_ofs;
   bank_idx_t        addr_bank;
   logic             in_window;
   logic             reg_hit;    // in window and a real register
   logic             is_err_reg;
   logic             err_clr;
   reg_data_t        rd_byte;
   reg_data_t        regs_q [`USB_REG_ERR_REG];
   reg_data_t        rdata_q;
   logic             err_q;

   // window decode, bits above the bank field must be zero
   assign reg_ofs    = bus.addr[OFS_W-1:0];
   assign addr_bank  = bus.addr[OFS_W +: IDX_W];
   assign in_window  = (addr_bank == bank_idx_t'(BANK_INDEX)) &&
                       (bus.addr[`USB_REG_ADDR_W-1:TOP_LSB] == '0);
   assign reg_hit    = in_window && (reg_ofs < `USB_REG_BANK_REGS);
   assign is_err_reg = (reg_ofs == OFS_W'(`USB_REG_ERR_REG));
   assign err_clr    = bus.wr_stb && reg_hit && is_err_reg && bus.wdata[0];

   always_comb begin
      rd_byte = '0;
      if (reg_hit) begin
         if (is_err_reg) begin
            rd_byte = reg_data_t'(err_q);  // sticky bit in bit 0
         end else begin
            rd_byte = regs_q[reg_ofs[REG_IDX_W-1:0]];
         end
      end
   end

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < `USB_REG_ERR_REG; i++) begin
            regs_q[i] <= '0;
         end
      end else if (bus.wr_stb && reg_hit && !is_err_reg) begin
         regs_q[reg_ofs[REG_IDX_W-1:0]] <= bus.wdata;
      end
   end

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         err_q <= 1'b0;
      end else if (err_event_i) begin
         err_q <= 1'b1;   // event beats a clear in the same cycle
      end else if (err_clr) begin
         err_q <= 1'b0;
      end
   end

   // zero unless this bank answers a read
   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rdata_q <= '0;
      end else begin
         rdata_q <= bus.rd_stb ? rd_byte : '0;
      end
   end

   assign rdata_o = rdata_q;
   assign err_o   = err_q;

   a_err_sets: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      err_event_i |=> err_o);

endmodule

// File: src/reg_host_port.sv
`timescale 1ns/1ps

module reg_host_port (
   input  logic                   clk_usb_buf,
   input  logic                   arst_n_i,
   input  logic                   req_i,
   input  logic                   we_i,
   input  usb_reg_pkg::reg_addr_t addr_i,
   input  usb_reg_pkg::reg_data_t wdata_i,
   input  usb_reg_pkg::reg_data_t rdata_q_i,
   output logic                   ack_o,
   output usb_reg_pkg::reg_data_t rdata_o,
   reg_bus_if.host                bus
);
   import usb_reg_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STROBE,
      ST_WAIT,
      ST_ACK
   } state_t;

   state_t    state_q;
   logic      wait_cnt_q;  // two wait stages, bank then collector
   logic      new_req;
   logic      wr_stb_q;
   logic      rd_stb_q;
   reg_addr_t addr_q;
   reg_data_t wdata_q;
   reg_data_t rdata_q;

   assign new_req = (state_q == ST_IDLE) && req_i;  // ack is low in idle

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q    <= ST_IDLE;
         wait_cnt_q <= 1'b0;
         wr_stb_q   <= 1'b0;
         rd_stb_q   <= 1'b0;
      end else begin
         wr_stb_q <= new_req && we_i;
         rd_stb_q <= new_req && !we_i;
         case (state_q)
            ST_IDLE: begin
               if (req_i) begin
                  state_q <= ST_STROBE;
               end
            end
            ST_STROBE: begin
               state_q    <= ST_WAIT;  // bank acts on this edge
               wait_cnt_q <= 1'b0;
            end
            ST_WAIT: begin
               wait_cnt_q <= 1'b1;
               if (wait_cnt_q) begin
                  state_q <= ST_ACK;   // collector output is valid now
               end
            end
            ST_ACK: begin
               if (!req_i) begin
                  state_q <= ST_IDLE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   // latch the request so the banks see a stable address
   always_ff @(posedge clk_usb_buf) begin
      if (new_req) begin
         addr_q  <= addr_i;
         wdata_q <= wdata_i;
      end
      if ((state_q == ST_WAIT) && wait_cnt_q) begin
         rdata_q <= rdata_q_i;
      end
   end

   assign bus.addr   = addr_q;
   assign bus.wdata  = wdata_q;
   assign bus.wr_stb = wr_stb_q;
   assign bus.rd_stb = rd_stb_q;

   assign ack_o   = (state_q == ST_ACK);
   assign rdata_o = rdata_q;

   // a strobe is a single pulse per access
   a_one_strobe: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      (wr_stb_q || rd_stb_q) |=> !(wr_stb_q || rd_stb_q));

   a_ack_needs_req: assert property (@(posedge clk_usb_buf) disable iff (!arst_n_i)
      $rose(ack_o) |-> req_i);

endmodule

// File: src/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;
   usb_reg_pkg::reg_addr_t addr;    // held for the whole access
   usb_reg_pkg::reg_data_t wdata;
   logic                   wr_stb;  // one cycle per write
   logic                   rd_stb;  // one cycle per read

   modport host (
      output addr,
      output wdata,
      output wr_stb,
      output rd_stb
   );

   modport bank (
      input addr,
      input wdata,
      input wr_stb,
      input rd_stb
   );
endinterface

// File: src/usb_reg_pkg.sv
`include "usb_reg_defines.svh"

package usb_reg_pkg;

   // byte address on the host register bus
   typedef logic [`USB_REG_ADDR_W-1:0] reg_addr_t;

   // register payload
   typedef logic [`USB_REG_DATA_W-1:0] reg_data_t;

   // bank number field of an address
   typedef logic [$clog2(`USB_REG_NUM_BANKS)-1:0] bank_idx_t;

endpackage

// File: src/usb_reg_defines.svh
`ifndef USB_REG_DEFINES_SVH
`define USB_REG_DEFINES_SVH

// bank layout
`define USB_REG_NUM_BANKS    4
`define USB_REG_BANK_REGS    8
`define USB_REG_BANK_STRIDE  16

// host bus widths
`define USB_REG_ADDR_W       8
`define USB_REG_DATA_W       8

// sticky error lives in the last register of a bank
`define USB_REG_ERR_REG      7

// led flash rate, msb toggles every 2**(W-1) cycles
`define USB_REG_FLASH_W      4

`endif
